//--- m72_cpu_glue.f
common/m72_glue_pkg.sv
hdl/cpu_clock_enable.sv
sdram_bridge/cpu_bus_lanes.sv
sdram_bridge/sdram_cpu_bridge.sv
hdl/cpu_read_mux.sv
hdl/io_ports.sv
hdl/m72_cpu_glue.sv
tests/glue_checker.sv
tests/m72_cpu_glue_tb.sv

//--- tests/m72_cpu_glue_tb.sv
// CPU glue testbench

module m72_cpu_glue_tb
    import m72_glue_pkg::*;
();

    localparam int ce_div_bits = 2;
    localparam logic [2:0] op_rd = 3'd0, op_wr = 3'd1, op_wrp = 3'd2;
    localparam logic [2:0] op_peri = 3'd3, op_io = 3'd4, op_flag = 3'd5;

    typedef struct packed {
        logic [2:0]  op;
        logic [19:0] addr;
        logic [15:0] wdata;
        logic [3:0]  src;        // Valid mask or port select
        logic [15:0] ret;        // SDRAM return word
        logic [17:0] exp_val;    // Write lanes in 17:16
    } row_t;

    row_t   rows [0:31];
    int     row_count;
    int     expected_reqs;
    int     timeout_count;
    int     resp_wait;
    integer seed = 2;

    logic CLK_32M = 1'b0, reset_n = 1'b0;
    logic mem_read = 1'b0, mem_write = 1'b0, rom_ram_sel = 1'b0, region_writable = 1'b0;
    logic [addr_w-1:0] mem_addr = '0;
    logic [1:0] mem_sel = 2'b11;
    logic [data_w-1:0] mem_dout = '0, sdr_dout = '0, sdram_word = '0;
    logic [sdr_addr_w-1:0] region_addr = '0;
    logic sdr_rdy = 1'b0, io_addr0 = 1'b0, fset = 1'b0;
    logic sw_sel = 1'b0, flag_sel = 1'b0, dsw_sel = 1'b0;
    logic [7:0] io_dout = '0;
    logic tile_valid = 1'b0, objpal_valid = 1'b0, sound_valid = 1'b0, sprite_valid = 1'b0;
    logic [data_w-1:0] tile_dout = 16'h7001, objpal_dout = 16'h7102, sound_dout = 16'h7203;
    logic [data_w-1:0] sprite_dout = 16'h7304, shared_dout = 16'h5E5E;
    logic [3:0] p1_joystick = 4'h1, p1_buttons = 4'h2, p2_joystick = 4'h3, p2_buttons = 4'h4;
    logic [1:0] coin = 2'b10, start_buttons = 2'b01;
    logic tnsl = 1'b1;
    logic [15:0] dip_sw = 16'h01A5;    // Bit 8 flips nl

    logic [data_w-1:0] mem_din, word_dout, sdr_din;
    logic [addr_w-1:0] word_addr;
    logic [sdr_addr_w-1:0] sdr_addr;
    logic [7:0] io_din;
    logic [1:0] word_sel, sdr_wr_sel, coin_out;
    logic ce_cpu, ce_4x_cpu, ce_mcu, read_any, write_any, sdr_req, cblk, brq, bank, nl;

    // Checker side
    logic check_en = 1'b0;
    logic [1:0] check_sel = '0, exp_wr_sel = '0;
    logic [31:0] check_val = '0;
    logic [sdr_addr_w-1:0] exp_addr = '0;
    logic [data_w-1:0] exp_din = '0;
    logic [addr_w-1:0] exp_word_addr = '0;
    logic exp_write = 1'b0;
    int error_count, req_count;

    m72_cpu_glue #(.ce_div_bits(ce_div_bits)) m72_cpu_glue_i (.*);
    glue_checker #(.ce_div_bits(ce_div_bits)) checker_i (.*);

    initial begin
        forever #4 CLK_32M = ~CLK_32M;
    end

    // SDRAM model, ready 2 to 6 cycles after each request
    always @(posedge CLK_32M) begin
        sdr_rdy <= 1'b0;
        if (sdr_req) begin
            resp_wait <= 1 + {$random(seed)} % 5;
        end else if (resp_wait == 1) begin
            sdr_rdy   <= 1'b1;
            sdr_dout  <= sdram_word;
            resp_wait <= 0;
        end else if (resp_wait > 1) begin
            resp_wait <= resp_wait - 1;
        end
    end

    task add_row(input logic [2:0] op, input logic [19:0] addr, input logic [15:0] wdata,
                 input logic [3:0] src, input logic [15:0] ret, input logic [17:0] exp_val);
        rows[row_count] = {op, addr, wdata, src, ret, exp_val};
        row_count++;
    endtask

    // Checker samples the DUT one edge later
    task check_port(input logic [1:0] sel, input logic [31:0] value);
        check_sel <= sel;
        check_val <= value;
        check_en  <= 1'b1;
        @(posedge CLK_32M);
        check_en  <= 1'b0;
    endtask

    task wait_signal(input int which, input int limit, input string what);
        int  n;
        bit  seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge CLK_32M);
            n++;
            case (which)
                0: seen = sdr_req;
                1: seen = sdr_rdy;
                default: seen = ce_cpu;
            endcase
        end
        if (!seen) begin
            $display("Timeout at %0t: no %s within %0d cycles", $time, what, limit);
            timeout_count++;
        end
    endtask

    task run_sdram(input row_t r);
        region_addr     <= {5'h02, r.addr[19:1]};
        exp_addr        <= {5'h02, r.addr[19:1]};
        exp_wr_sel      <= r.exp_val[17:16];
        exp_din         <= r.exp_val[15:0];
        exp_word_addr   <= {r.addr[19:1], 1'b0};
        exp_write       <= (r.op != op_rd);
        region_writable <= (r.op == op_wr);
        mem_addr        <= r.addr;
        mem_dout        <= r.wdata;
        mem_sel         <= r.addr[0] ? 2'b01 : 2'b11;
        sdram_word      <= r.ret;
        rom_ram_sel     <= 1'b1;
        if (r.op == op_rd) mem_read <= 1'b1;
        else mem_write <= 1'b1;
        expected_reqs++;
        wait_signal(0, 10, "sdr_req");
        // Second strobe edge while the request is open
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        @(posedge CLK_32M);
        if (r.op == op_rd) mem_read <= 1'b1;
        else mem_write <= 1'b1;
        wait_signal(1, 12, "sdr_rdy");
        mem_read    <= 1'b0;
        mem_write   <= 1'b0;
        rom_ram_sel <= 1'b0;
        if (r.op == op_rd) check_port(0, r.exp_val);
        else @(posedge CLK_32M);
        wait_signal(2, (1 << ce_div_bits) + 1, "ce_cpu pulse after sdr_rdy");
    endtask

    task apply_row(input row_t r);
        case (r.op)
            op_peri: begin
                mem_addr <= r.addr;
                {sprite_valid, sound_valid, objpal_valid, tile_valid} <= r.src;
                @(posedge CLK_32M);
                check_port(0, r.exp_val);
            end
            op_io: begin
                io_addr0 <= r.addr[0];
                {dsw_sel, flag_sel, sw_sel} <= r.src[2:0];
                check_port(1, r.exp_val);
            end
            op_flag: begin
                io_addr0 <= r.addr[0];
                io_dout  <= r.wdata[7:0];
                fset     <= 1'b1;
                @(posedge CLK_32M);
                fset <= 1'b0;
                check_port(2, r.exp_val);    // {coin_out, cblk, bank, brq, nl}
            end
            default: run_sdram(r);
        endcase
        {sprite_valid, sound_valid, objpal_valid, tile_valid} <= 4'b0000;
        {dsw_sel, flag_sel, sw_sel} <= 3'b000;
        repeat (2) @(posedge CLK_32M);
    endtask

    // ==============================
    // Stimulus table
    // ==============================
    initial begin
        add_row(op_rd,   20'h01234, 16'h0000, 4'h0, 16'hBEEF, 18'h0BEEF);
        add_row(op_rd,   20'h04567, 16'h0000, 4'h0, 16'hCAFE, 18'h000CA);
        add_row(op_wr,   20'h20010, 16'h1357, 4'h0, 16'h0000, 18'h31357);
        add_row(op_wr,   20'h20011, 16'h2468, 4'h0, 16'h0000, 18'h26800);
        add_row(op_wrp,  20'h30020, 16'h9999, 4'h0, 16'h0000, 18'h00000);
        add_row(op_peri, 20'h10000, 16'h0000, 4'hF, 16'h0000, 18'h07001);
        add_row(op_peri, 20'h10000, 16'h0000, 4'hE, 16'h0000, 18'h07102);
        add_row(op_peri, 20'h10000, 16'h0000, 4'hC, 16'h0000, 18'h07203);
        add_row(op_peri, 20'hB0000, 16'h0000, 4'h8, 16'h0000, 18'h07304);
        add_row(op_peri, 20'hB0100, 16'h0000, 4'h0, 16'h0000, 18'h05E5E);
        add_row(op_peri, 20'hB0101, 16'h0000, 4'h0, 16'h0000, 18'h0005E);
        add_row(op_peri, 20'h10001, 16'h0000, 4'h1, 16'h0000, 18'h00070);
        add_row(op_io,   20'h00000, 16'h0000, 4'h1, 16'h0000, 18'h00021);
        add_row(op_io,   20'h00001, 16'h0000, 4'h1, 16'h0000, 18'h00043);
        add_row(op_io,   20'h00000, 16'h0000, 4'h2, 16'h0000, 18'h000F9);
        add_row(op_io,   20'h00001, 16'h0000, 4'h4, 16'h0000, 18'h00001);
        add_row(op_io,   20'h00000, 16'h0000, 4'h0, 16'h0000, 18'h000FF);
        add_row(op_flag, 20'h00000, 16'h002B, 4'h0, 16'h0000, 18'h0003E);
        add_row(op_flag, 20'h00001, 16'h0014, 4'h0, 16'h0000, 18'h0003E);
        add_row(op_flag, 20'h00000, 16'h0015, 4'h0, 16'h0000, 18'h00011);

        repeat (10) @(posedge CLK_32M);
        reset_n <= 1'b1;
        repeat (2) @(posedge CLK_32M);
        check_port(2, 32'h2);    // Flags out of reset
        for (int i = 0; i < row_count; i++) begin
            apply_row(rows[i]);
        end
        check_port(3, expected_reqs);
        @(posedge CLK_32M);

        $display("Summary: %0d value errors, %0d timeouts, %0d SDRAM requests",
                 error_count, timeout_count, req_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/glue_checker.sv
// CPU glue response checker

module glue_checker
    import m72_glue_pkg::*;
#(
    parameter int ce_div_bits = 2
) (
    input  logic                  CLK_32M,
    input  logic                  reset_n,
    input  logic                  sdr_req,
    input  logic                  sdr_rdy,
    input  logic [sdr_addr_w-1:0] sdr_addr,
    input  logic [1:0]            sdr_wr_sel,
    input  logic [data_w-1:0]     sdr_din,
    input  logic                  ce_cpu,
    input  logic                  ce_4x_cpu,
    input  logic                  ce_mcu,
    input  logic                  read_any,
    input  logic                  write_any,
    input  logic [addr_w-1:0]     word_addr,
    input  logic [data_w-1:0]     word_dout,
    input  logic [1:0]            word_sel,
    input  logic [data_w-1:0]     mem_din,
    input  logic [7:0]            io_din,
    input  logic                  cblk,
    input  logic                  bank,
    input  logic                  brq,
    input  logic                  nl,
    input  logic [1:0]            coin_out,
    input  logic                  check_en,
    input  logic [1:0]            check_sel,
    input  logic [31:0]           check_val,
    input  logic [sdr_addr_w-1:0] exp_addr,
    input  logic [1:0]            exp_wr_sel,
    input  logic [data_w-1:0]     exp_din,
    input  logic [addr_w-1:0]     exp_word_addr,
    input  logic                  exp_write,
    output int                    error_count,
    output int                    req_count
);

    logic        pending;    // Request out, ready not seen yet
    logic        mcu_seen;
    int          mcu_gap;
    logic [31:0] got;

    always_comb begin
        case (check_sel)
            2'd0: got = {16'h0000, mem_din};
            2'd1: got = {24'h000000, io_din};
            2'd2: got = {26'h0000000, coin_out, cblk, bank, brq, nl};
            default: got = req_count;
        endcase
    end

    always @(posedge CLK_32M or negedge reset_n) begin : compare
        int errs;
        errs = 0;
        if (!reset_n) begin
            pending     <= 1'b0;
            mcu_seen    <= 1'b0;
            mcu_gap     <= 0;
            error_count <= 0;
            req_count   <= 0;
        end else begin
            if (check_en && got !== check_val) begin
                $display("** Error at %0t: check %0d read %h, expected %h",
                         $time, check_sel, got, check_val);
                errs++;
            end
            if (sdr_req) begin
                if (pending) begin
                    $display("** Error at %0t: sdr_req during an open request", $time);
                    errs++;
                end
                // Write data only matters when a lane is enabled
                if (sdr_addr !== exp_addr || sdr_wr_sel !== exp_wr_sel ||
                    (exp_wr_sel != 2'b00 && sdr_din !== exp_din)) begin
                    $display("** Error at %0t: request %h/%b/%h, expected %h/%b/%h",
                             $time, sdr_addr, sdr_wr_sel, sdr_din,
                             exp_addr, exp_wr_sel, exp_din);
                    errs++;
                end
                if (read_any !== ~exp_write || write_any !== exp_write ||
                    word_addr !== exp_word_addr ||
                    (exp_wr_sel != 2'b00 &&
                     (word_sel !== exp_wr_sel || word_dout !== exp_din))) begin
                    $display("** Error at %0t: lanes %b%b/%h/%b/%h, expected write %b at %h",
                             $time, read_any, write_any, word_addr, word_sel, word_dout,
                             exp_write, exp_word_addr);
                    errs++;
                end
                req_count <= req_count + 1;
                pending   <= 1'b1;
            end
            if (sdr_rdy) pending <= 1'b0;
            if ((sdr_req || pending) && (ce_cpu || ce_4x_cpu)) begin
                $display("** Error at %0t: CPU enable pulsed while SDRAM request open", $time);
                errs++;
            end

            // MCU enable runs at a fixed rate
            if (ce_mcu) begin
                if (mcu_seen && mcu_gap != (1 << ce_div_bits) - 1) begin
                    $display("** Error at %0t: ce_mcu gap %0d, expected %0d",
                             $time, mcu_gap + 1, 1 << ce_div_bits);
                    errs++;
                end
                mcu_gap  <= 0;
                mcu_seen <= 1'b1;
            end else begin
                if (mcu_gap == (1 << ce_div_bits)) begin
                    $display("** Error at %0t: ce_mcu pulse missing", $time);
                    errs++;
                end
                mcu_gap <= mcu_gap + 1;
            end
            error_count <= error_count + errs;
        end
    end

endmodule

//--- hdl/m72_cpu_glue.sv
// M72 main CPU glue top level

module m72_cpu_glue
    import m72_glue_pkg::*;
#(
    parameter int ce_div_bits = 2
) (
    input  logic                  CLK_32M,
    input  logic                  reset_n,

    // CPU bus
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [addr_w-1:0]     mem_addr,
    input  logic [1:0]            mem_sel,
    input  logic [data_w-1:0]     mem_dout,
    output logic [data_w-1:0]     mem_din,
    input  logic                  io_addr0,
    input  logic [7:0]            io_dout,
    output logic [7:0]            io_din,
    output logic                  ce_cpu,
    output logic                  ce_4x_cpu,
    output logic                  ce_mcu,

    // Aligned bus towards the peripheral boards
    output logic                  read_any,
    output logic                  write_any,
    output logic [addr_w-1:0]     word_addr,
    output logic [data_w-1:0]     word_dout,
    output logic [1:0]            word_sel,

    // Board decode
    input  logic                  rom_ram_sel,
    input  logic [sdr_addr_w-1:0] region_addr,
    input  logic                  region_writable,
    input  logic                  sw_sel,
    input  logic                  flag_sel,
    input  logic                  dsw_sel,
    input  logic                  fset,

    // Peripheral returns
    input  logic [data_w-1:0]     tile_dout,
    input  logic                  tile_valid,
    input  logic [data_w-1:0]     objpal_dout,
    input  logic                  objpal_valid,
    input  logic [data_w-1:0]     sound_dout,
    input  logic                  sound_valid,
    input  logic [data_w-1:0]     sprite_dout,
    input  logic                  sprite_valid,
    input  logic [data_w-1:0]     shared_dout,

    // SDRAM port
    output logic [sdr_addr_w-1:0] sdr_addr,
    output logic [data_w-1:0]     sdr_din,
    output logic [1:0]            sdr_wr_sel,
    output logic                  sdr_req,
    input  logic [data_w-1:0]     sdr_dout,
    input  logic                  sdr_rdy,

    // Player inputs
    input  logic [3:0]            p1_joystick,
    input  logic [3:0]            p2_joystick,
    input  logic [3:0]            p1_buttons,
    input  logic [3:0]            p2_buttons,
    input  logic [1:0]            coin,
    input  logic [1:0]            start_buttons,
    input  logic                  tnsl,
    input  logic [15:0]           dip_sw,

    // System flags
    output logic                  cblk,
    output logic                  brq,
    output logic                  bank,
    output logic                  nl,
    output logic [1:0]            coin_out
);

    logic              access_start;
    logic              mem_busy;
    logic              cpu_stall;
    logic [data_w-1:0] ram_rom_data;

    assign cpu_stall = rom_ram_sel | mem_busy;    // Hold CPU during fetch

    cpu_clock_enable #(
        .ce_div_bits(ce_div_bits)
    ) cpu_clock_enable_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n), .stall(cpu_stall),
        .ce_cpu(ce_cpu), .ce_4x_cpu(ce_4x_cpu), .ce_mcu(ce_mcu)
    );

    cpu_bus_lanes cpu_bus_lanes_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_sel(mem_sel), .mem_dout(mem_dout),
        .read_any(read_any), .write_any(write_any), .access_start(access_start),
        .word_addr(word_addr), .word_dout(word_dout), .word_sel(word_sel)
    );

    sdram_cpu_bridge sdram_cpu_bridge_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .access_start(access_start), .rom_ram_sel(rom_ram_sel), .write_any(write_any),
        .region_addr(region_addr), .region_writable(region_writable),
        .word_dout(word_dout), .word_sel(word_sel),
        .sdr_addr(sdr_addr), .sdr_din(sdr_din), .sdr_wr_sel(sdr_wr_sel),
        .sdr_req(sdr_req), .sdr_dout(sdr_dout), .sdr_rdy(sdr_rdy),
        .ram_rom_data(ram_rom_data), .mem_busy(mem_busy)
    );

    cpu_read_mux cpu_read_mux_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n), .mem_addr(mem_addr),
        .tile_dout(tile_dout), .objpal_dout(objpal_dout),
        .sound_dout(sound_dout), .sprite_dout(sprite_dout),
        .tile_valid(tile_valid), .objpal_valid(objpal_valid),
        .sound_valid(sound_valid), .sprite_valid(sprite_valid),
        .shared_dout(shared_dout), .ram_rom_data(ram_rom_data), .mem_din(mem_din)
    );

    io_ports io_ports_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n), .io_addr0(io_addr0), .io_dout(io_dout),
        .fset(fset), .sw_sel(sw_sel), .flag_sel(flag_sel), .dsw_sel(dsw_sel),
        .p1_joystick(p1_joystick), .p2_joystick(p2_joystick),
        .p1_buttons(p1_buttons), .p2_buttons(p2_buttons),
        .coin(coin), .start_buttons(start_buttons), .tnsl(tnsl), .dip_sw(dip_sw),
        .io_din(io_din), .cblk(cblk), .brq(brq), .bank(bank), .nl(nl),
        .coin_out(coin_out)
    );

endmodule

//--- hdl/io_ports.sv
// I/O input ports and system flags

module io_ports
    import m72_glue_pkg::*;
(
    input  logic        CLK_32M,
    input  logic        reset_n,
    input  logic        io_addr0,
    input  logic [7:0]  io_dout,
    input  logic        fset,
    input  logic        sw_sel,
    input  logic        flag_sel,
    input  logic        dsw_sel,
    input  logic [3:0]  p1_joystick,
    input  logic [3:0]  p2_joystick,
    input  logic [3:0]  p1_buttons,
    input  logic [3:0]  p2_buttons,
    input  logic [1:0]  coin,
    input  logic [1:0]  start_buttons,
    input  logic        tnsl,
    input  logic [15:0] dip_sw,
    output logic [7:0]  io_din,
    output logic        cblk,
    output logic        brq,
    output logic        bank,
    output logic        nl,
    output logic [1:0]  coin_out
);

    logic [7:0]  sys_flags;
    logic [15:0] switch_word;
    logic [15:0] flag_word;
    logic [15:0] port_word;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) sys_flags <= '0;
        else if (fset && !io_addr0) sys_flags <= io_dout;    // Even port only
    end

    assign coin_out = {sys_flags[flag_coin1], sys_flags[flag_coin0]};
    assign cblk     = sys_flags[flag_cblk];
    assign bank     = sys_flags[flag_bank];
    assign brq      = ~sys_flags[flag_brq];
    assign nl       = ~sys_flags[flag_soft_nl] ^ dip_sw[8];    // DIP flips the screen

    // ==============================
    // Port read
    // ==============================
    assign switch_word = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
    assign flag_word   = {io_idle_byte, tnsl, 3'b111, coin, start_buttons};

    always_comb begin
        if (sw_sel) port_word = switch_word;
        else if (flag_sel) port_word = flag_word;
        else if (dsw_sel) port_word = dip_sw;
        else port_word = {io_idle_byte, io_idle_byte};
    end

    assign io_din = io_addr0 ? port_word[15:8] : port_word[7:0];

endmodule

//--- hdl/cpu_read_mux.sv
// CPU memory read data select

module cpu_read_mux
    import m72_glue_pkg::*;
(
    input  logic              CLK_32M,
    input  logic              reset_n,
    input  logic [addr_w-1:0] mem_addr,
    input  logic [data_w-1:0] tile_dout,
    input  logic [data_w-1:0] objpal_dout,
    input  logic [data_w-1:0] sound_dout,
    input  logic [data_w-1:0] sprite_dout,
    input  logic              tile_valid,
    input  logic              objpal_valid,
    input  logic              sound_valid,
    input  logic              sprite_valid,
    input  logic [data_w-1:0] shared_dout,
    input  logic [data_w-1:0] ram_rom_data,
    output logic [data_w-1:0] mem_din
);

    logic tile_valid_d;
    logic objpal_valid_d;
    logic sound_valid_d;
    logic sprite_valid_d;
    logic [data_w-1:0] read_word;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            tile_valid_d   <= 1'b0;
            objpal_valid_d <= 1'b0;
            sound_valid_d  <= 1'b0;
            sprite_valid_d <= 1'b0;
        end else begin
            tile_valid_d   <= tile_valid;
            objpal_valid_d <= objpal_valid;
            sound_valid_d  <= sound_valid;
            sprite_valid_d <= sprite_valid;
        end
    end

    // Peripherals first, then shared page, then SDRAM
    always_comb begin
        if (tile_valid_d) read_word = tile_dout;
        else if (objpal_valid_d) read_word = objpal_dout;
        else if (sound_valid_d) read_word = sound_dout;
        else if (sprite_valid_d) read_word = sprite_dout;
        else if (mem_addr[addr_w-1 -: 4] == shared_ram_page) read_word = shared_dout;
        else read_word = ram_rom_data;
    end

    // Odd address gets the high byte in the low lane
    assign mem_din = mem_addr[0] ? {8'h00, read_word[15:8]} : read_word;

endmodule

//--- sdram_bridge/sdram_cpu_bridge.sv
// CPU request path to SDRAM

module sdram_cpu_bridge
    import m72_glue_pkg::*;
(
    input  logic                  CLK_32M,
    input  logic                  reset_n,
    input  logic                  access_start,
    input  logic                  rom_ram_sel,
    input  logic                  write_any,
    input  logic [sdr_addr_w-1:0] region_addr,
    input  logic                  region_writable,
    input  logic [data_w-1:0]     word_dout,
    input  logic [1:0]            word_sel,
    output logic [sdr_addr_w-1:0] sdr_addr,
    output logic [data_w-1:0]     sdr_din,
    output logic [1:0]            sdr_wr_sel,
    output logic                  sdr_req,
    input  logic [data_w-1:0]     sdr_dout,
    input  logic                  sdr_rdy,
    output logic [data_w-1:0]     ram_rom_data,
    output logic                  mem_busy
);

    logic accept;

    // New edges are dropped while a request is open
    assign accept = access_start & rom_ram_sel & ~mem_busy;

    // ==============================
    // Request handshake
    // ==============================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sdr_req  <= 1'b0;
            mem_busy <= 1'b0;
        end else begin
            sdr_req <= 1'b0;    // Single cycle pulse
            if (accept) begin
                sdr_req  <= 1'b1;
                mem_busy <= 1'b1;
            end else if (mem_busy && sdr_rdy) begin
                mem_busy <= 1'b0;
            end
        end
    end

    // Request payload and returned word
    always_ff @(posedge CLK_32M) begin
        if (accept) begin
            sdr_addr   <= region_addr;
            sdr_wr_sel <= 2'b00;    // Read unless writable
            if (write_any && region_writable) begin
                sdr_wr_sel <= word_sel;
                sdr_din    <= word_dout;
            end
        end

        if (mem_busy && sdr_rdy) begin
            ram_rom_data <= sdr_dout;
        end
    end

endmodule

//--- sdram_bridge/cpu_bus_lanes.sv
// CPU strobe edges and byte lane alignment

module cpu_bus_lanes
    import m72_glue_pkg::*;
(
    input  logic              CLK_32M,
    input  logic              reset_n,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [addr_w-1:0] mem_addr,
    input  logic [1:0]        mem_sel,
    input  logic [data_w-1:0] mem_dout,
    output logic              read_any,
    output logic              write_any,
    output logic              access_start,
    output logic [addr_w-1:0] word_addr,
    output logic [data_w-1:0] word_dout,
    output logic [1:0]        word_sel
);

    logic mem_read_d;
    logic mem_write_d;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            mem_read_d  <= 1'b0;
            mem_write_d <= 1'b0;
        end else begin
            mem_read_d  <= mem_read;
            mem_write_d <= mem_write;
        end
    end

    // Strobe stretched by one cycle
    assign read_any  = mem_read | mem_read_d;
    assign write_any = mem_write | mem_write_d;

    assign access_start = (mem_read & ~mem_read_d) | (mem_write & ~mem_write_d);

    // ==============================
    // Word alignment
    // ==============================
    // Odd byte rides in the high lane
    assign word_addr = {mem_addr[addr_w-1:1], 1'b0};
    assign word_dout = mem_addr[0] ? {mem_dout[7:0], 8'h00} : mem_dout;
    assign word_sel  = mem_addr[0] ? {mem_sel[0], 1'b0} : mem_sel;

endmodule

//--- hdl/cpu_clock_enable.sv
// CPU and MCU clock enables

module cpu_clock_enable #(
    parameter int ce_div_bits = 2
) (
    input  logic CLK_32M,
    input  logic reset_n,
    input  logic stall,
    output logic ce_cpu,
    output logic ce_4x_cpu,
    output logic ce_mcu
);

    logic [ce_div_bits-1:0] cpu_count;
    logic [ce_div_bits-1:0] mcu_count;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            cpu_count <= '0;
            mcu_count <= '0;
            ce_cpu    <= 1'b0;
            ce_4x_cpu <= 1'b0;
            ce_mcu    <= 1'b0;
        end else begin
            ce_cpu    <= 1'b0;
            ce_4x_cpu <= 1'b0;

            // CPU side freezes during a memory fetch
            if (!stall) begin
                cpu_count <= cpu_count + 1'b1;
                ce_4x_cpu <= 1'b1;
                ce_cpu    <= &cpu_count;    // Pulse on wrap
            end

            mcu_count <= mcu_count + 1'b1;
            ce_mcu    <= &mcu_count;
        end
    end

endmodule

//--- common/m72_glue_pkg.sv
// M72 CPU glue shared definitions

package m72_glue_pkg;

    // ==============================
    // Bus widths
    // ==============================
    localparam int addr_w     = 20;    // CPU byte address
    localparam int data_w     = 16;    // CPU data word
    localparam int sdr_addr_w = 24;    // SDRAM word address, bits 24..1

    // ==============================
    // Memory map
    // ==============================
    // Top nibble of the shared RAM window
    localparam logic [3:0] shared_ram_page = 4'hB;

    // ==============================
    // System flag byte
    // ==============================
    localparam int flag_coin0   = 0;
    localparam int flag_coin1   = 1;
    localparam int flag_soft_nl = 2;    // Inverted on the way out
    localparam int flag_cblk    = 3;
    localparam int flag_brq     = 4;    // Inverted on the way out
    localparam int flag_bank    = 5;

    // Open port reads back as pulled-up lines
    localparam logic [7:0] io_idle_byte = 8'hFF;

endpackage
